//--- hw/rv_pkg.sv
// RV32I core shared types
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    // branch funct3 encodings
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_pc_a;    // operand a = pc
        logic       zero_a;      // operand a = 0, for lui
        logic       use_imm_b;   // operand b = imm
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_load;
        logic       is_store;
        logic [2:0] mem_funct3;  // size and sign, branch condition too
        logic       link;        // rd gets pc+4
        logic       rd_we;
        logic [4:0] rd;
    } ctrl_t;

    // wishbone classic master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- hw/fetch_unit.sv
// instruction fetch and program counter
`default_nettype none

module fetch_unit #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h0000_0000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    retire,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    output rv_pkg::wb_req_t         ibus_req,
    input  rv_pkg::wb_rsp_t         ibus_rsp,
    output logic [rv_pkg::xlen-1:0] pc,
    output rv_pkg::inst_u           inst,
    output logic                    inst_valid
);

    typedef enum logic [1:0] {
        REQUEST,   // first fetch after reset
        WAIT_ACK,  // bus cycle open
        EXECUTE    // word held until retire
    } state_t;

    state_t state;
    logic   ack_seen;

    assign ack_seen = (state == WAIT_ACK) && ibus_rsp.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= REQUEST;
            pc         <= reset_pc;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                REQUEST: state <= WAIT_ACK;
                WAIT_ACK: begin
                    if (ibus_rsp.ack) begin
                        state      <= EXECUTE;
                        inst_valid <= 1'b1;  // one cycle after the ack edge
                    end
                end
                EXECUTE: begin
                    if (retire) begin
                        // next request goes out right away
                        state <= WAIT_ACK;
                        pc    <= next_pc;
                    end
                end
                default: state <= REQUEST;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (ack_seen) begin
            inst <= ibus_rsp.dat;
        end
    end

    always_comb begin
        ibus_req     = '0;
        ibus_req.cyc = (state == WAIT_ACK);
        ibus_req.stb = (state == WAIT_ACK);
        ibus_req.we  = 1'b0;
        ibus_req.adr = pc;
        ibus_req.sel = 4'b1111;  // always a full word
    end

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
// instruction decoder
`default_nettype none

module decode_unit (
    input  rv_pkg::inst_u           inst,
    output rv_pkg::ctrl_t           ctrl,
    output logic [rv_pkg::xlen-1:0] imm,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2
);
    import rv_pkg::*;

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign rs1 = inst.r_fmt.rs1;
    assign rs2 = inst.r_fmt.rs2;

    always_comb begin
        ctrl            = '0;
        ctrl.alu_op     = ADD;
        ctrl.rd         = inst.r_fmt.rd;
        ctrl.mem_funct3 = inst.r_fmt.funct3;
        imm             = '0;

        case (inst.r_fmt.opcode)
            OP: begin
                ctrl.alu_op = alu_sel(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
                ctrl.rd_we  = 1'b1;
            end
            OP_IMM: begin
                imm            = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                // addi has no sub form, only srai looks at bit 30
                ctrl.alu_op    = alu_sel(inst.i_fmt.funct3,
                                         inst.i_fmt.funct3 == 3'b101 && inst.i_fmt.imm[10]);
                ctrl.use_imm_b = 1'b1;
                ctrl.rd_we     = 1'b1;
            end
            LOAD: begin
                imm            = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                ctrl.use_imm_b = 1'b1;
                ctrl.is_load   = 1'b1;
                ctrl.rd_we     = 1'b1;
            end
            STORE: begin
                imm            = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                                  inst.s_fmt.imm_4_0};
                ctrl.use_imm_b = 1'b1;
                ctrl.is_store  = 1'b1;
            end
            BRANCH: begin
                imm            = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                                  inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
                ctrl.is_branch = 1'b1;
            end
            JAL: begin
                imm          = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                                inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
                ctrl.is_jal  = 1'b1;
                ctrl.link    = 1'b1;
                ctrl.rd_we   = 1'b1;
            end
            JALR: begin
                imm            = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                ctrl.use_imm_b = 1'b1;  // target = rs1 + imm
                ctrl.is_jalr   = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.rd_we     = 1'b1;
            end
            LUI: begin
                imm            = {inst.u_fmt.imm_31_12, 12'h000};
                ctrl.zero_a    = 1'b1;
                ctrl.use_imm_b = 1'b1;
                ctrl.rd_we     = 1'b1;
            end
            AUIPC: begin
                imm            = {inst.u_fmt.imm_31_12, 12'h000};
                ctrl.use_pc_a  = 1'b1;
                ctrl.use_imm_b = 1'b1;
                ctrl.rd_we     = 1'b1;
            end
            default: ;  // unknown opcode, retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
// general register file
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [4:0]              rd,
    input  logic                    rd_we,
    input  logic [rv_pkg::xlen-1:0] rd_wdata
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != 5'd0) begin  // x0 never written
            regs[rd] <= rd_wdata;
        end
    end

    // asynchronous read
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
// ALU, branch compare and next pc
`default_nettype none

module execute_unit (
    input  rv_pkg::ctrl_t           ctrl,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic [rv_pkg::xlen-1:0] link_pc,
    output logic [rv_pkg::xlen-1:0] next_pc
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            taken;

    // operand select
    always_comb begin
        if (ctrl.zero_a) begin
            op_a = '0;
        end else if (ctrl.use_pc_a) begin
            op_a = pc;
        end else begin
            op_a = rs1_data;
        end
        op_b = ctrl.use_imm_b ? imm : rs2_data;
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {31'd0, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = $unsigned($signed(op_a) >>> shamt);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    // branch compare always on the two registers
    always_comb begin
        case (branch_e'(ctrl.mem_funct3))
            BEQ:     taken = (rs1_data == rs2_data);
            BNE:     taken = (rs1_data != rs2_data);
            BLT:     taken = ($signed(rs1_data) < $signed(rs2_data));
            BGE:     taken = ($signed(rs1_data) >= $signed(rs2_data));
            BLTU:    taken = (rs1_data < rs2_data);
            BGEU:    taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign link_pc = pc + 32'd4;

    always_comb begin
        if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
            next_pc = pc + imm;
        end else if (ctrl.is_jalr) begin
            next_pc = {alu_result[xlen-1:1], 1'b0};
        end else begin
            next_pc = link_pc;
        end
    end

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
// data bus master and write-back select
`default_nettype none

module load_store_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::ctrl_t           ctrl,
    input  logic                    inst_valid,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic [rv_pkg::xlen-1:0] link_pc,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output rv_pkg::wb_req_t         dbus_req,
    input  rv_pkg::wb_rsp_t         dbus_rsp,
    output logic                    rd_we,
    output logic [rv_pkg::xlen-1:0] rd_wdata,
    output logic                    retire
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t      state;
    logic        is_mem;
    logic [1:0]  offset;     // byte within the word
    logic [31:0] lane_data;  // load word shifted down to bit 0
    logic [31:0] load_data;

    assign is_mem = ctrl.is_load || ctrl.is_store;
    assign offset = alu_result[1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (inst_valid && is_mem) state <= BUSY;
                BUSY:    if (dbus_rsp.ack) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        dbus_req     = '0;
        dbus_req.cyc = (state == BUSY);
        dbus_req.stb = (state == BUSY);
        dbus_req.we  = ctrl.is_store;
        dbus_req.adr = {alu_result[31:2], 2'b00};
        case (ctrl.mem_funct3[1:0])
            2'b00: begin
                dbus_req.sel = 4'b0001 << offset;
                dbus_req.dat = {4{rs2_data[7:0]}};
            end
            2'b01: begin
                dbus_req.sel = 4'b0011 << {offset[1], 1'b0};
                dbus_req.dat = {2{rs2_data[15:0]}};
            end
            default: begin
                dbus_req.sel = 4'b1111;
                dbus_req.dat = rs2_data;
            end
        endcase
    end

    // load data comes straight off the bus on the ack cycle
    assign lane_data = dbus_rsp.dat >> {offset, 3'b000};

    always_comb begin
        case (ctrl.mem_funct3)
            3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};    // lb
            3'b100:  load_data = {24'd0, lane_data[7:0]};                 // lbu
            3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};  // lh
            3'b101:  load_data = {16'd0, lane_data[15:0]};                // lhu
            default: load_data = dbus_rsp.dat;
        endcase
    end

    // non-memory ops finish with inst_valid, memory ops on ack
    assign retire = (inst_valid && !is_mem) || (state == BUSY && dbus_rsp.ack);
    assign rd_we  = retire && ctrl.rd_we;

    always_comb begin
        if (ctrl.is_load) begin
            rd_wdata = load_data;
        end else if (ctrl.link) begin
            rd_wdata = link_pc;
        end else begin
            rd_wdata = alu_result;
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
// RV32I multicycle core top
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset,
    output rv_pkg::wb_req_t ibus_req,
    input  rv_pkg::wb_rsp_t ibus_rsp,
    output rv_pkg::wb_req_t dbus_req,
    input  rv_pkg::wb_rsp_t dbus_rsp
);
    import rv_pkg::*;

    inst_u           inst;
    logic [xlen-1:0] pc;
    logic            inst_valid;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] link_pc;
    logic [xlen-1:0] rd_wdata;
    logic            rd_we;
    logic            retire;  // end of current instruction

    fetch_unit #(.reset_pc(reset_pc)) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .retire     (retire),
        .next_pc    (next_pc),
        .ibus_req   (ibus_req),
        .ibus_rsp   (ibus_rsp),
        .pc         (pc),
        .inst       (inst),
        .inst_valid (inst_valid)
    );

    decode_unit u_decode (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm),
        .rs1  (rs1),
        .rs2  (rs2)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd       (ctrl.rd),
        .rd_we    (rd_we),
        .rd_wdata (rd_wdata)
    );

    execute_unit u_execute (
        .ctrl       (ctrl),
        .pc         (pc),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .link_pc    (link_pc),
        .next_pc    (next_pc)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .inst_valid (inst_valid),
        .alu_result (alu_result),
        .link_pc    (link_pc),
        .rs2_data   (rs2_data),
        .dbus_req   (dbus_req),
        .dbus_rsp   (dbus_rsp),
        .rd_we      (rd_we),
        .rd_wdata   (rd_wdata),
        .retire     (retire)
    );

endmodule

`default_nettype wire

//--- verification/tb_wb_memory.sv
// Wishbone classic memory model
`default_nettype none

module tb_wb_memory #(
    parameter int unsigned depth = 256,
    parameter logic [31:0] base  = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::wb_req_t req,
    output rv_pkg::wb_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [depth];
    logic [15:0] lfsr;
    logic [1:0]  wait_cnt;  // cycles left before ack
    logic        busy;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per delay bit
    task automatic draw_delay(output logic [1:0] d);
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            d[i] = lfsr[0];
        end
    endtask

    function automatic int word_index(input logic [31:0] adr);
        return int'(((adr - base) >> 2) % depth);
    endfunction

    // slave acts 1 ns after each edge on the current request
    initial begin
        int idx;
        lfsr     = 16'd97;
        wait_cnt = 2'd0;
        busy     = 1'b0;
        rsp      = '0;
        for (int i = 0; i < depth; i++) begin
            mem[i] = 32'hdead_0000 ^ (base + 4 * i);  // whole byte address in the fill
        end
        forever begin
            @(posedge clk);
            #1;
            if (reset || !(req.cyc && req.stb) || rsp.ack) begin
                rsp.ack = 1'b0;
                busy    = 1'b0;
            end else begin
                if (!busy) begin
                    draw_delay(wait_cnt);
                    busy = 1'b1;
                end else begin
                    wait_cnt = wait_cnt - 2'd1;
                end
                if (wait_cnt == 2'd0) begin
                    idx = word_index(req.adr);
                    if (req.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (req.sel[b]) mem[idx][8*b +: 8] = req.dat[8*b +: 8];
                        end
                    end
                    rsp.dat = mem[idx];
                    rsp.ack = 1'b1;  // single cycle ack
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_rv_core.sv
// RV32I core testbench
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam logic [31:0] prog_base = 32'h0000_1000;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    typedef struct packed {
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } store_t;

    logic    clk;
    logic    reset;
    wb_req_t ibus_req;
    wb_rsp_t ibus_rsp;
    wb_req_t dbus_req;
    wb_rsp_t dbus_rsp;

    logic [31:0] prog [$];
    logic [31:0] fetch_q [$];  // expected ibus addresses in order
    store_t      store_q [$];
    int          cycle = 0;
    int          cycle_limit;
    logic        done = 1'b0;

    rv_core #(.reset_pc(prog_base)) dut (
        .clk      (clk),
        .reset    (reset),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp)
    );

    tb_wb_memory #(.depth(64), .base(prog_base)) imem (
        .clk   (clk),
        .reset (reset),
        .req   (ibus_req),
        .rsp   (ibus_rsp)
    );

    tb_wb_memory #(.depth(256), .base(32'h0)) dmem (
        .clk   (clk),
        .reset (reset),
        .req   (dbus_req),
        .rsp   (dbus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else report_fail($sformatf("ERROR t=%0t ns %s expected 0x%08h actual 0x%08h",
                                   $time, name, exp, act));
    endtask

    // instruction encoders, fields in bit order
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                opc_branch};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expect_store(input logic [31:0] adr, input logic [3:0] sel,
                                input logic [31:0] dat);
        store_t s;
        s.adr = adr;
        s.sel = sel;
        s.dat = dat;
        store_q.push_back(s);
    endtask

    task automatic expect_fetch_range(input logic [31:0] first, input logic [31:0] last);
        for (logic [31:0] a = first; a <= last; a += 32'd4) begin
            fetch_q.push_back(a);
        end
    endtask

    // program from 0x1000, expected stores beside each check
    task automatic build_program();
        emit(enc_i(-5, 0, 0, 1, opc_imm));       // addi x1, x0, -5
        emit(enc_i(3, 0, 0, 2, opc_imm));        // addi x2, x0, 3
        emit(enc_r('h20, 2, 1, 0, 3));           // sub x3, x1, x2
        emit(enc_s('h10, 3, 0, 2));
        expect_store(32'h10, 4'hf, 32'hffff_fff8);  // -5 - 3
        emit(enc_r(0, 2, 2, 1, 4));              // sll x4, x2, x2
        emit(enc_s('h14, 4, 0, 2));
        expect_store(32'h14, 4'hf, 32'h0000_0018);
        emit(enc_i('h401, 1, 5, 5, opc_imm));    // srai x5, x1, 1
        emit(enc_s('h18, 5, 0, 2));
        expect_store(32'h18, 4'hf, 32'hffff_fffd);  // sign bit kept
        emit(enc_r(0, 2, 1, 5, 6));              // srl x6, x1, x2
        emit(enc_s('h1c, 6, 0, 2));
        expect_store(32'h1c, 4'hf, 32'h1fff_ffff);
        emit(enc_r(0, 2, 1, 2, 7));              // slt x7, x1, x2
        emit(enc_s('h20, 7, 0, 2));
        expect_store(32'h20, 4'hf, 32'h0000_0001);  // -5 < 3 signed
        emit(enc_r(0, 2, 1, 3, 8));              // sltu x8, x1, x2
        emit(enc_s('h24, 8, 0, 2));
        expect_store(32'h24, 4'hf, 32'h0000_0000);
        emit(enc_i('hf0, 1, 4, 9, opc_imm));     // xori x9, x1, 0xf0
        emit(enc_s('h28, 9, 0, 2));
        expect_store(32'h28, 4'hf, 32'hffff_ff0b);
        emit(enc_r(0, 4, 2, 6, 10));             // or x10, x2, x4
        emit(enc_s('h2c, 10, 0, 2));
        expect_store(32'h2c, 4'hf, 32'h0000_001b);
        emit(enc_i('h7f, 1, 7, 11, opc_imm));    // andi x11, x1, 0x7f
        emit(enc_s('h30, 11, 0, 2));
        expect_store(32'h30, 4'hf, 32'h0000_007b);
        emit(enc_u('habcde, 12, opc_lui));
        emit(enc_s('h34, 12, 0, 2));
        expect_store(32'h34, 4'hf, 32'habcd_e000);
        emit(enc_u(1, 13, opc_auipc));           // at 0x1058
        emit(enc_s('h38, 13, 0, 2));
        expect_store(32'h38, 4'hf, 32'h0000_2058);
        emit(enc_i(55, 0, 0, 0, opc_imm));       // write to x0 is dropped
        emit(enc_s('h3c, 0, 0, 2));
        expect_store(32'h3c, 4'hf, 32'h0000_0000);
        // loads from 0x8081_f0f2 at address 0
        emit(enc_i(1, 0, 0, 14, opc_load));      // lb, byte 1
        emit(enc_s('h40, 14, 0, 2));
        expect_store(32'h40, 4'hf, 32'hffff_fff0);
        emit(enc_i(3, 0, 4, 15, opc_load));      // lbu, byte 3
        emit(enc_s('h44, 15, 0, 2));
        expect_store(32'h44, 4'hf, 32'h0000_0080);
        emit(enc_i(2, 0, 1, 16, opc_load));      // lh, upper half
        emit(enc_s('h48, 16, 0, 2));
        expect_store(32'h48, 4'hf, 32'hffff_8081);
        emit(enc_i(0, 0, 5, 17, opc_load));      // lhu, lower half
        emit(enc_s('h4c, 17, 0, 2));
        expect_store(32'h4c, 4'hf, 32'h0000_f0f2);
        emit(enc_i(0, 0, 2, 18, opc_load));      // lw
        emit(enc_s('h50, 18, 0, 2));
        expect_store(32'h50, 4'hf, 32'h8081_f0f2);
        emit(enc_s('h55, 1, 0, 0));              // sb x1 to lane 1
        expect_store(32'h54, 4'b0010, 32'hfbfb_fbfb);
        emit(enc_s('h5a, 9, 0, 1));              // sh x9 to upper half
        expect_store(32'h58, 4'b1100, 32'hff0b_ff0b);
        // control flow from 0x1098
        emit(enc_b(8, 2, 2, 0));                 // beq taken
        emit(enc_i(1, 0, 0, 19, opc_imm));       // skipped
        emit(enc_b(8, 2, 2, 1));                 // bne not taken
        emit(enc_i(0, 0, 0, 20, opc_imm));
        emit(enc_i(1, 20, 0, 20, opc_imm));      // blt loop top at 0x10a8
        emit(enc_b(-4, 2, 20, 4));               // blt x20, x2
        emit(enc_s('h60, 20, 0, 2));
        expect_store(32'h60, 4'hf, 32'h0000_0003);  // three passes
        emit(enc_i(2, 0, 0, 21, opc_imm));
        emit(enc_i(1, 0, 0, 22, opc_imm));
        emit(enc_i(-1, 21, 0, 21, opc_imm));     // bgeu loop top at 0x10bc
        emit(enc_b(-4, 22, 21, 7));              // bgeu x21, x22
        emit(enc_j(12, 23));                     // jal at 0x10c4 to 0x10d0
        emit(enc_i(2, 0, 0, 19, opc_imm));       // skipped
        emit(enc_i(3, 0, 0, 19, opc_imm));       // skipped
        emit(enc_s('h64, 23, 0, 2));
        expect_store(32'h64, 4'hf, 32'h0000_10c8);  // jal address + 4
        emit(enc_u(1, 24, opc_lui));
        emit(enc_i('he5, 24, 0, 25, opc_jalr));  // jalr at 0x10d8, bit 0 cleared
        emit(enc_i(4, 0, 0, 19, opc_imm));       // skipped
        emit(enc_i(5, 0, 0, 19, opc_imm));       // skipped
        emit(enc_s('h68, 25, 0, 2));
        expect_store(32'h68, 4'hf, 32'h0000_10dc);  // jalr address + 4
        emit(enc_s('h6c, 19, 0, 2));
        expect_store(32'h6c, 4'hf, 32'h0000_0000);  // no skipped op ran
        emit(enc_s('hfc, 2, 0, 2));              // final store
        expect_store(32'hfc, 4'hf, 32'h0000_0003);

        expect_fetch_range(32'h1000, 32'h1098);
        expect_fetch_range(32'h10a0, 32'h10ac);
        expect_fetch_range(32'h10a8, 32'h10ac);
        expect_fetch_range(32'h10a8, 32'h10ac);
        expect_fetch_range(32'h10b0, 32'h10c0);
        expect_fetch_range(32'h10bc, 32'h10c4);
        expect_fetch_range(32'h10d0, 32'h10d8);
        expect_fetch_range(32'h10e4, 32'h10ec);
    endtask

    // fetch order and captured stores
    always @(posedge clk) begin
        store_t exp;
        if (!reset && !done) begin
            if (ibus_req.stb && ibus_rsp.ack) begin
                if (fetch_q.size() == 0) begin
                    report_fail("fetch past the end of the program");
                end else begin
                    check_value("ibus_req.adr", fetch_q.pop_front(), ibus_req.adr);
                    check_value("ibus_req.sel", 32'h0000_000f, {28'd0, ibus_req.sel});
                    check_value("ibus_req.we", 32'd0, {31'd0, ibus_req.we});  // reads only
                end
            end
            if (dbus_req.stb && dbus_rsp.ack && dbus_req.we) begin
                if (store_q.size() == 0) begin
                    report_fail("store that the program does not make");
                end else begin
                    exp = store_q.pop_front();
                    check_value("dbus_req.adr", exp.adr, dbus_req.adr);
                    check_value("dbus_req.sel", {28'd0, exp.sel}, {28'd0, dbus_req.sel});
                    check_value("dbus_req.dat", exp.dat, dbus_req.dat);
                    if (dbus_req.adr == 32'h0000_00fc) done <= 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) (reset && cycle != 0) |->
        !(ibus_req.cyc || ibus_req.stb || dbus_req.cyc || dbus_req.stb ||
          dut.retire || dut.inst_valid || dut.rd_we))
    else report_fail("bus cycle or retire active during reset");

    assert property (@(posedge clk) disable iff (reset)
        (ibus_req.stb && !ibus_rsp.ack) |=> $stable(ibus_req))
    else report_fail("ibus request changed while waiting for ack");

    assert property (@(posedge clk) disable iff (reset)
        (ibus_req.stb && ibus_rsp.ack) |=> !(ibus_req.cyc || ibus_req.stb))
    else report_fail("ibus cyc or stb still high after ack");

    assert property (@(posedge clk) disable iff (reset)
        (dbus_req.stb && !dbus_rsp.ack) |=> $stable(dbus_req))
    else report_fail("dbus request changed while waiting for ack");

    assert property (@(posedge clk) disable iff (reset)
        (dbus_req.stb && dbus_rsp.ack) |=> !(dbus_req.cyc || dbus_req.stb))
    else report_fail("dbus cyc or stb still high after ack");

    initial begin
        reset = 1'b1;
        build_program();
        cycle_limit = 40 * prog.size() + 10;
        @(posedge clk);
        #1;
        // models have done their own fill by now
        for (int i = 0; i < prog.size(); i++) begin
            imem.mem[i] = prog[i];
        end
        dmem.mem[0] = 32'h8081_f0f2;
        repeat (9) @(posedge clk);
        #1 reset = 1'b0;

        while (!done && cycle < cycle_limit) @(posedge clk);
        if (done && fetch_q.size() == 0 && store_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else if (!done) begin
            report_fail($sformatf("timeout after %0d cycles, final store never seen", cycle));
        end else begin
            report_fail("final store seen with expected fetches or stores left over");
        end
    end

endmodule

`default_nettype wire

//--- files.f
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/load_store_unit.sv
hw/rv_core.sv
verification/tb_wb_memory.sv
verification/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
